/* verilog/sm_mem_pkg.sv */
`default_nettype none

package sm_mem_pkg;

    // data word as seen on the load/store port
    typedef logic [31:0] word_t;

    // byte address; the two low bits are ignored by the memories
    typedef logic [31:0] addr_t;

    // word index inside one RAM, up to 256 words
    typedef logic [7:0] index_t;

    // one load/store access
    typedef struct packed {
        addr_t addr;    // byte address, or word index once rebased
        logic  we;      // write enable
        word_t wd;      // write data
    } mem_req_t;

    // slow RAM sequencing
    typedef enum logic [1:0] {
        S_IDLE  = 2'h0, // waiting for a request
        S_BUSY  = 2'h1, // counting the delay, not ready
        S_READY = 2'h2  // data presented
    } busy_state_t;

endpackage

`default_nettype wire

/* verilog/sm_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module sm_ram
    import sm_mem_pkg::*;
#(
    parameter int SIZE = 64     // memory size in words, at most 256
)
(
    input  wire         clk,
    input  wire index_t index,  // word index, wraps at SIZE
    input  wire         we,     // write strobe
    input  wire word_t  wd,     // write data
    output word_t       rd      // read data, asynchronous
);

    word_t mem [SIZE];          // storage, no reset

    // write at the rising edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index % SIZE] <= wd;
        end
    end

    // read path has no register
    assign rd = mem[index % SIZE];

endmodule

`default_nettype wire

/* verilog/sm_ram_busy.sv */
`timescale 1ns/100ps
`default_nettype none

module sm_ram_busy
    import sm_mem_pkg::*;
#(
    parameter int SIZE  = 64,   // memory size in words
    parameter int DELAY = 7     // access latency, 2 to 255
)
(
    input  wire           clk,
    input  wire           reset,
    input  wire           valid,    // read/write request
    input  wire mem_req_t req,      // addr already holds the word index
    output logic          ready,    // read/write done
    output word_t         rd        // read data
);

    busy_state_t state;
    busy_state_t state_next;
    logic [7:0]  delay;             // cycles spent in S_BUSY
    logic        delay_finished;
    mem_req_t    ibuf;              // buffered request
    logic        ibuf_we;
    index_t      ram_index;
    logic        ram_we;

    assign delay_finished = (delay == 8'(DELAY - 2));

    // next state
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:  state_next = valid ? S_BUSY : S_IDLE;
            S_BUSY:  state_next = delay_finished ? S_READY : S_BUSY;
            S_READY: state_next = S_IDLE;
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // delay counter runs only while busy
    always_ff @(posedge clk) begin
        if (reset || state != S_BUSY) begin
            delay <= '0;
        end else begin
            delay <= delay + 8'd1;
        end
    end

    // ready strobe
    always_comb begin
        case (state)
            S_IDLE:  ready = ~valid;    // idle readiness
            S_BUSY:  ready = 1'b0;
            S_READY: ready = 1'b1;
            default: ready = 1'b0;
        endcase
    end

    // request is taken once, when leaving S_IDLE
    assign ibuf_we = (state == S_IDLE) && valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ibuf <= '0;
        end else if (ibuf_we) begin
            ibuf <= req;
        end
    end

    // RAM sees only the buffer
    assign ram_index = index_t'(ibuf.addr);
    assign ram_we    = ibuf.we && (state == S_READY); // write lands at completion

    sm_ram #(
        .SIZE  ( SIZE )
    ) ram (
        .clk   ( clk       ),
        .index ( ram_index ),
        .we    ( ram_we    ),
        .wd    ( ibuf.wd   ),
        .rd    ( rd        )
    );

endmodule

`default_nettype wire

/* verilog/sm_mem_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module sm_mem_decode
    import sm_mem_pkg::*;
#(
    parameter int FAST_SIZE = 64,   // fast RAM words
    parameter int SLOW_SIZE = 64    // slow RAM words
)
(
    input  wire           clk,
    input  wire           reset,

    // master side
    input  wire           valid,
    input  wire mem_req_t req,
    output logic          ready,
    output word_t         rd,
    output logic          err,      // access outside both regions

    // fast RAM
    output index_t        fast_index,
    output logic          fast_we,
    output word_t         fast_wd,
    input  wire word_t    fast_rd,

    // slow RAM
    output logic          slow_valid,
    output mem_req_t      slow_req,
    input  wire           slow_ready,
    input  wire word_t    slow_rd
);

    // region bounds in bytes
    localparam addr_t SLOW_BASE = addr_t'(FAST_SIZE * 4);
    localparam addr_t SLOW_END  = addr_t'((FAST_SIZE + SLOW_SIZE) * 4);

    logic  fast_hit;
    logic  slow_hit;
    logic  miss;
    addr_t slow_offset;             // byte offset inside the slow region
    logic  err_q;                   // error of the last completed access

    // address compare
    assign fast_hit = (req.addr < SLOW_BASE);
    assign slow_hit = !fast_hit && (req.addr < SLOW_END);
    assign miss     = !fast_hit && !slow_hit;

    // fast RAM, same cycle
    assign fast_index = index_t'(req.addr >> 2);
    assign fast_we    = valid && fast_hit && req.we;
    assign fast_wd    = req.wd;

    // slow RAM, rebased to a word index
    assign slow_offset = req.addr - SLOW_BASE;
    assign slow_valid  = valid && slow_hit;
    assign slow_req    = '{
        addr: {2'b00, slow_offset[31:2]},
        we:   req.we,
        wd:   req.wd
    };

    // response mux
    always_comb begin
        if (fast_hit) begin
            ready = 1'b1;
            rd    = fast_rd;
        end else if (slow_hit) begin
            ready = slow_ready;     // idle readiness too
            rd    = slow_rd;
        end else begin
            ready = 1'b1;           // misses complete at once
            rd    = '0;
        end
    end

    // keep the status of the last completion
    always_ff @(posedge clk) begin
        if (reset) begin
            err_q <= 1'b0;
        end else if (valid && ready) begin
            err_q <= miss;
        end
    end

    // live while a request is up, held otherwise
    assign err = valid ? miss : err_q;

endmodule

`default_nettype wire

/* verilog/sm_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sm_mem_top
    import sm_mem_pkg::*;
#(
    parameter int FAST_SIZE = 64,   // fast RAM words
    parameter int SLOW_SIZE = 64,   // slow RAM words
    parameter int DELAY     = 7     // slow latency, 2 to 255
)
(
    input  wire           clk,
    input  wire           reset,
    input  wire           valid,    // request strobe
    input  wire mem_req_t req,      // held until ready
    output logic          ready,    // request done
    output word_t         rd,       // read data
    output logic          err       // address out of range
);

    index_t   fast_index;
    logic     fast_we;
    word_t    fast_wd;
    word_t    fast_rd;
    logic     slow_valid;
    mem_req_t slow_req;
    logic     slow_ready;
    word_t    slow_rd;

    sm_mem_decode #(
        .FAST_SIZE  ( FAST_SIZE  ),
        .SLOW_SIZE  ( SLOW_SIZE  )
    ) i_decode (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .valid      ( valid      ),
        .req        ( req        ),
        .ready      ( ready      ),
        .rd         ( rd         ),
        .err        ( err        ),
        .fast_index ( fast_index ),
        .fast_we    ( fast_we    ),
        .fast_wd    ( fast_wd    ),
        .fast_rd    ( fast_rd    ),
        .slow_valid ( slow_valid ),
        .slow_req   ( slow_req   ),
        .slow_ready ( slow_ready ),
        .slow_rd    ( slow_rd    )
    );

    // zero wait state region
    sm_ram #(
        .SIZE  ( FAST_SIZE  )
    ) i_fast_ram (
        .clk   ( clk        ),
        .index ( fast_index ),
        .we    ( fast_we    ),
        .wd    ( fast_wd    ),
        .rd    ( fast_rd    )
    );

    sm_ram_busy #(
        .SIZE  ( SLOW_SIZE  ),
        .DELAY ( DELAY      )
    ) i_slow_ram (
        .clk   ( clk        ),
        .reset ( reset      ),
        .valid ( slow_valid ),
        .req   ( slow_req   ),
        .ready ( slow_ready ),
        .rd    ( slow_rd    )
    );

endmodule

`default_nettype wire

/* dv/sm_mem_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module sm_mem_checker
    import sm_mem_pkg::*;
#(
    parameter int FAST_SIZE = 64,   // fast RAM words
    parameter int SLOW_SIZE = 64,   // slow RAM words
    parameter int DELAY     = 7     // slow latency in cycles
)
(
    input  wire           clk,
    input  wire           reset,
    input  wire           valid,
    input  wire mem_req_t req,
    input  wire           ready,
    input  wire word_t    rd,
    input  wire           err,
    output int            errors,       // mismatches and protocol faults
    output int            completions   // requests seen to complete
);

    // expected response of one access
    typedef struct packed {
        word_t       data;
        logic        err;
        logic [31:0] latency;
    } expect_t;

    localparam int unsigned REGION_END = (FAST_SIZE + SLOW_SIZE) * 4;

    word_t   ref_mem [FAST_SIZE + SLOW_SIZE];  // fast words first, then slow
    expect_t expected;
    logic    in_flight;         // request seen, not yet completed
    logic    last_err;          // err of the last completion
    int      cycle;
    int      start_cycle;       // edge where valid was first sampled
    int      latency;

    // address map and latency rules of the subsystem
    function automatic expect_t predict(input mem_req_t r);
        expect_t     e;
        int unsigned widx;
        widx      = r.addr >> 2;
        e.data    = '0;
        e.err     = 1'b0;
        e.latency = 0;
        if (r.addr >= REGION_END) begin
            e.err = 1'b1;                       // miss, immediate, zero data
        end else begin
            e.data = ref_mem[widx];
            if (widx >= FAST_SIZE) begin
                e.latency = DELAY;
            end
        end
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    initial begin
        errors      = 0;
        completions = 0;
        cycle       = 0;
        start_cycle = 0;
        in_flight   = 1'b0;
        last_err    = 1'b0;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (reset) begin
            in_flight = 1'b0;
            last_err  = 1'b0;
        end else if (!valid) begin
            if (in_flight) begin
                $display("ERROR t=%0t: valid dropped before the request completed", $time);
                errors++;
                in_flight = 1'b0;
            end
            compare_value("ready", 32'd1, {31'd0, ready}); // idle readiness
            compare_value("err", {31'd0, last_err}, {31'd0, err}); // held status
        end else begin
            if (!in_flight) begin
                in_flight   = 1'b1;
                start_cycle = cycle;
            end
            if (ready === 1'b1) begin
                expected = predict(req);
                latency  = cycle - start_cycle;
                completions++;
                compare_value("latency", expected.latency, latency);
                compare_value("err", {31'd0, expected.err}, {31'd0, err});
                if (!req.we || expected.err) begin
                    compare_value("rd", expected.data, rd);
                end
                if (req.we && !expected.err) begin
                    ref_mem[req.addr >> 2] = req.wd;    // write lands at completion
                end
                in_flight = 1'b0;
                last_err  = expected.err;
            end else if (ready !== 1'b0) begin
                $display("ERROR t=%0t: ready is unknown during a request", $time);
                errors++;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_sm_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sm_mem
    import sm_mem_pkg::*;
();

    localparam int    FAST_SIZE = 64;
    localparam int    SLOW_SIZE = 64;
    localparam int    DELAY     = 7;
    localparam int    TIMEOUT   = 50;   // cycles allowed per request
    localparam addr_t SLOW_BASE = addr_t'(FAST_SIZE * 4);
    localparam addr_t MISS_BASE = addr_t'((FAST_SIZE + SLOW_SIZE) * 4);

    logic        clk;
    logic        reset;
    logic        valid;
    mem_req_t    req;
    logic        ready;
    word_t       rd;
    logic        err;
    logic [31:0] lfsr;
    int          tb_errors;
    logic        timed_out;
    int          chk_errors;
    int          completions;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
        return value;
    endfunction

    // mostly fast and slow hits, a few misses
    function automatic addr_t rand_addr();
        logic [31:0] sel;
        logic [31:0] idx;
        logic [31:0] low;
        addr_t       a;
        sel = rand_bits(4);
        idx = rand_bits(8);
        low = rand_bits(2);
        if (sel < 7) begin
            a = ((idx % FAST_SIZE) << 2) | low;
        end else if (sel < 14) begin
            a = SLOW_BASE + ((idx % SLOW_SIZE) << 2) + low;
        end else begin
            a = MISS_BASE + (idx << 2) + low;
        end
        return a;
    endfunction

    // called on a falling edge, returns on the falling edge after completion
    task automatic access(input addr_t address, input logic write, input word_t data);
        int waited;
        if (!timed_out) begin
            valid  = 1'b1;
            req    = '{addr: address, we: write, wd: data};
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (ready !== 1'b1 && waited < TIMEOUT);
            if (ready !== 1'b1) begin
                $display("ERROR t=%0t: no ready within %0d cycles for address %h",
                         $time, TIMEOUT, address);
                tb_errors++;
                timed_out = 1'b1;
            end
            @(negedge clk);
            valid = 1'b0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        addr_t       addr;
        logic        we;
        word_t       wd;
        logic [31:0] gap;
        reset     = 1'b1;
        valid     = 1'b0;
        req       = '0;
        lfsr      = 32'd96;
        tb_errors = 0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        req.addr = SLOW_BASE + 32'h8;       // slow address, no request
        idle_cycles(3);

        for (int i = 0; i < FAST_SIZE + SLOW_SIZE; i++) begin
            access(addr_t'(i * 4), 1'b1, rand_bits(32));    // fill both regions
        end

        access(32'h10, 1'b1, 32'hCAFE_0001);    // fast write then read
        access(32'h13, 1'b0, '0);
        access(SLOW_BASE + 32'h20, 1'b1, 32'hBEEF_0002);
        access(SLOW_BASE + 32'h20, 1'b0, '0);
        access(SLOW_BASE + 32'h21, 1'b0, '0);

        access(MISS_BASE + 32'h14, 1'b1, 32'hDEAD_0003);    // aliases word 5
        access(32'hFFFF_FFF0, 1'b1, 32'hDEAD_0004);
        access(MISS_BASE + 32'h14, 1'b0, '0);
        access(32'h14, 1'b0, '0);
        access(SLOW_BASE + 32'h14, 1'b0, '0);

        access(32'h24, 1'b1, 32'hAAAA_0009);    // same index, both regions
        access(SLOW_BASE + 32'h24, 1'b1, 32'h5555_0009);
        access(32'h24, 1'b0, '0);
        access(SLOW_BASE + 32'h24, 1'b0, '0);

        for (int i = 0; i < 400; i++) begin
            addr = rand_addr();
            we   = 1'(rand_bits(1));
            wd   = rand_bits(32);
            gap  = rand_bits(2);
            access(addr, we, wd);
            if (gap == 0) begin
                idle_cycles(1);
            end
        end

        idle_cycles(3);
        $display("completions %0d, checker errors %0d, testbench errors %0d",
                 completions, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    sm_mem_top #(
        .FAST_SIZE ( FAST_SIZE ),
        .SLOW_SIZE ( SLOW_SIZE ),
        .DELAY     ( DELAY     )
    ) i_dut (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .valid     ( valid     ),
        .req       ( req       ),
        .ready     ( ready     ),
        .rd        ( rd        ),
        .err       ( err       )
    );

    sm_mem_checker #(
        .FAST_SIZE   ( FAST_SIZE   ),
        .SLOW_SIZE   ( SLOW_SIZE   ),
        .DELAY       ( DELAY       )
    ) i_checker (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .valid       ( valid       ),
        .req         ( req         ),
        .ready       ( ready       ),
        .rd          ( rd          ),
        .err         ( err         ),
        .errors      ( chk_errors  ),
        .completions ( completions )
    );

endmodule

`default_nettype wire

/* all.f */
verilog/sm_mem_pkg.sv
verilog/sm_ram.sv
verilog/sm_ram_busy.sv
verilog/sm_mem_decode.sv
verilog/sm_mem_top.sv
dv/sm_mem_checker.sv
dv/tb_sm_mem.sv
